/* src.f */
hdl/imem_pkg.sv
hdl/instr_mem.sv
hdl/program_loader.sv
hdl/fetch_unit.sv
hdl/imem_arbiter.sv
hdl/imem_top.sv
verification/tb_clock_gen.sv
verification/imem_checker.sv
verification/imem_sva.sv
verification/tb_imem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_imem
RTL_TOP   := imem_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Result: fail"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Result: no verdict in $(LOG)"; exit 1; fi
	@echo "Result: pass"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_imem.sv */
`default_nettype none

// Testbench for the instruction memory subsystem
// Load phase, straight fetch, mixed traffic, then a fetch across the top address
module tb_imem;

  import imem_pkg::*;

  localparam logic [31:0] SEED     = 32'h10ab_51bc;
  localparam int          PERIOD   = 40;
  localparam int          RST_CYC  = 8;
  localparam int          N_LOAD   = 64;    // Words in the first program
  localparam int          N_MIXED  = 800;   // Cycles of mixed traffic
  // Worst case two cycles per loaded word, plus idle, readback and wrap phases
  localparam int          N_CYCLES = RST_CYC + 3 * N_LOAD + N_MIXED + 40;
  localparam int          WD_TIME  = N_CYCLES * PERIOD + 100 * PERIOD;

  logic  i_clk;
  logic  i_rsta;
  logic  i_load_start;
  logic  i_load_valid;
  word_t i_load_word;
  logic  i_run;
  logic  i_branch;
  addr_t i_branch_target;
  word_t o_instr;
  addr_t o_instr_pc;
  logic  o_instr_valid;
  addr_t o_load_count;

  logic [31:0] lfsr;            // Stimulus LFSR state
  int          mismatches;      // From the checker
  int          instr_checked;
  int          other_errors;

  tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RST_CYC)) clkgen0 (
    .o_clk  (i_clk),
    .o_rsta (i_rsta)
  );

  imem_top dut0 (.*);

  imem_checker chk0 (
    .i_instr         (o_instr),
    .i_instr_pc      (o_instr_pc),
    .i_instr_valid   (o_instr_valid),
    .i_load_count    (o_load_count),
    .o_mismatches    (mismatches),
    .o_instr_checked (instr_checked),
    .*
  );

  // Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // n fresh bits, one LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // One clock of stimulus, applied just after the rising edge
  task automatic drive_cycle(input logic start, input logic valid, input word_t word,
                             input logic run, input logic br, input addr_t target);
    @(posedge i_clk);
    i_load_start    <= start;
    i_load_valid    <= valid;
    i_load_word     <= word;
    i_run           <= run;
    i_branch        <= br;
    i_branch_target <= target;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic fetch_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, '0, 1'b1, 1'b0, '0);
  endtask

  // Program from address 0, start arrives together with the first word
  task automatic load_program(input int n);
    int k;
    k = 0;
    while (k < n) begin
      if (k > 0 && rand_bits(2) == 0) begin
        drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);   // Gap in the word stream
      end else begin
        drive_cycle(k == 0, 1'b1, rand_bits(32), 1'b0, 1'b0, '0);
        k++;
      end
    end
  endtask

  // Fetching with loader writes, reloads, branches and run drops
  task automatic mixed_traffic(input int n);
    logic  valid;
    logic  start;
    logic  run;
    logic  br;
    addr_t target;
    for (int c = 0; c < n; c++) begin
      valid = rand_bits(3) == 0;              // Write stalls the fetch
      start = rand_bits(6) == 0;              // Rare pointer restart, with or without a word
      run   = rand_bits(5) != 0;
      br    = rand_bits(3) == 0;
      if (rand_bits(1) != 0) begin
        target = addr_t'(rand_bits(6));       // Inside the loaded program
      end else begin
        target = addr_t'(IMEM_DEPTH - 4) + addr_t'(rand_bits(2));  // Wraps soon
      end
      drive_cycle(start, valid, rand_bits(32), run, br, target);
    end
  endtask

  // Closing summary and verdict
  task automatic end_run(input logic timed_out);
    int sva_fails;
    sva_fails = dut0.u_arb.sva0.fail_count;
    if (timed_out) begin
      other_errors++;
    end
    if (instr_checked == 0) begin
      $display("No instruction was compared during the run");
      other_errors++;
    end
    $display("Summary: %0d mismatches, %0d assertion failures, %0d other errors, %0d instructions",
             mismatches, sva_fails, other_errors, instr_checked);
    if (mismatches + sva_fails + other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  initial begin
    lfsr            = SEED;
    other_errors    = 0;
    i_load_start    = 1'b0;
    i_load_valid    = 1'b0;
    i_load_word     = '0;
    i_run           = 1'b0;
    i_branch        = 1'b0;
    i_branch_target = '0;
    do begin
      @(posedge i_clk);
    end while (i_rsta);
    idle_cycles(4);                            // Run low, nothing may come out
    load_program(N_LOAD);
    idle_cycles(2);
    fetch_cycles(N_LOAD + 4);                  // Readback from address 0
    mixed_traffic(N_MIXED);
    drive_cycle(1'b0, 1'b0, '0, 1'b1, 1'b1, addr_t'(IMEM_DEPTH - 3));
    fetch_cycles(8);                           // Crosses 2047 -> 0
    idle_cycles(4);
    end_run(1'b0);
  end

  // Watchdog
  initial begin
    #(WD_TIME);
    $display("Timeout: stimulus did not finish within %0d time units", WD_TIME);
    end_run(1'b1);
  end

endmodule

`default_nettype wire

/* verification/imem_sva.sv */
`default_nettype none

// Port-sharing rules of the arbiter
module imem_sva (
  input wire i_clk,
  input wire i_rsta,
  input wire i_wr_req,
  input wire i_rd_req,
  input wire i_gnt,
  input wire i_rvalid,
  input wire i_mem_ena
);

  int fail_count = 0;   // Tally for the closing summary

  // Loader owns the port whenever it asks
  a_no_gnt_on_write: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_wr_req |-> !i_gnt)
    else begin
      $error("Fetch granted while the loader requests a write");
      fail_count++;
    end

  // Read data is tagged only after a granted read
  a_rvalid_after_gnt: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_rvalid |-> $past(i_gnt))
    else begin
      $error("Read valid without a grant in the previous cycle");
      fail_count++;
    end

  a_ena_needs_req: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_mem_ena |-> (i_wr_req || i_rd_req))
    else begin
      $error("RAM enabled with no request pending");
      fail_count++;
    end

endmodule

bind imem_arbiter imem_sva sva0 (
  .i_clk     (i_clk),
  .i_rsta    (i_rsta),
  .i_wr_req  (i_wr_req),
  .i_rd_req  (i_rd_req),
  .i_gnt     (o_gnt),
  .i_rvalid  (o_rvalid),
  .i_mem_ena (o_mem_ena)
);

`default_nettype wire

/* verification/imem_checker.sv */
`default_nettype none

// Reference model of RAM, program counter and loader
// Everything is sampled on the falling edge, away from the rising-edge updates
module imem_checker (
  input  wire                  i_clk,
  input  wire                  i_rsta,
  input  wire                  i_load_start,
  input  wire                  i_load_valid,
  input  wire imem_pkg::word_t i_load_word,
  input  wire                  i_run,
  input  wire                  i_branch,
  input  wire imem_pkg::addr_t i_branch_target,
  input  wire imem_pkg::word_t i_instr,        // DUT outputs from here on
  input  wire imem_pkg::addr_t i_instr_pc,
  input  wire                  i_instr_valid,
  input  wire imem_pkg::addr_t i_load_count,
  output int                   o_mismatches,
  output int                   o_instr_checked
);

  import imem_pkg::*;

  word_t model_mem [IMEM_DEPTH];   // Expected RAM contents
  addr_t model_pc;                 // Next fetch address
  addr_t model_ptr;                // Next load address, equals the load count
  logic  model_run;                // Fetch FSM in RUN
  logic  pend_valid;               // Read issued last cycle, result due now
  addr_t pend_addr;
  word_t pend_word;
  logic  armed = 1'b0;             // Set once a reset was seen

  initial begin
    o_mismatches    = 0;
    o_instr_checked = 0;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      model_mem[i] = '0;           // RAM powers up cleared
    end
  end

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch %s at %0t: dut=%h expected=%h", name, $time, got, exp);
    o_mismatches++;
  endtask

  always @(negedge i_clk) begin : model_step
    logic  wr;
    logic  issue;
    addr_t wr_addr;
    // Outputs left by the last rising edge
    if (armed) begin
      if (i_instr_valid !== pend_valid) begin
        mismatch("o_instr_valid", 32'(i_instr_valid), 32'(pend_valid));
      end else if (pend_valid) begin
        if (i_instr !== pend_word) mismatch("o_instr", i_instr, pend_word);
        if (i_instr_pc !== pend_addr) begin
          mismatch("o_instr_pc", 32'(i_instr_pc), 32'(pend_addr));
        end
        o_instr_checked++;
      end
      if (i_load_count !== model_ptr) begin
        mismatch("o_load_count", 32'(i_load_count), 32'(model_ptr));
      end
    end
    // Advance by this cycle's inputs
    if (i_rsta) begin
      model_pc   = '0;
      model_ptr  = '0;
      model_run  = 1'b0;
      pend_valid = 1'b0;
      armed      = 1'b1;
    end else begin
      wr      = i_load_valid;
      wr_addr = i_load_start ? addr_t'(0) : model_ptr;
      issue   = model_run && !i_branch && !wr;    // Write owns the port
      if (wr) model_mem[wr_addr] = i_load_word;
      pend_valid = issue;
      if (issue) begin
        pend_word = model_mem[model_pc];
        pend_addr = model_pc;
      end
      if (i_branch) begin
        model_pc = i_branch_target;
      end else if (issue) begin
        model_pc = model_pc + 1'b1;               // Wraps at the top
      end
      if (wr) begin
        model_ptr = wr_addr + 1'b1;
      end else if (i_load_start) begin
        model_ptr = '0;
      end
      model_run = i_run;
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

// Free-running clock and a synchronous reset for the first cycles
module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rsta
);

  initial begin
    o_clk  = 1'b0;
    o_rsta = 1'b1;                         // Held from time zero
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Release just after a rising edge, like the other inputs
  initial begin
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rsta <= 1'b0;
  end

endmodule

`default_nettype wire

/* hdl/imem_top.sv */
`default_nettype none

// Instruction memory subsystem
// Loader and fetch unit share one RAM port through the arbiter
module imem_top (
  input  wire                  i_clk,
  input  wire                  i_rsta,
  input  wire                  i_load_start,
  input  wire                  i_load_valid,
  input  wire imem_pkg::word_t i_load_word,
  input  wire                  i_run,
  input  wire                  i_branch,
  input  wire imem_pkg::addr_t i_branch_target,
  output imem_pkg::word_t      o_instr,
  output imem_pkg::addr_t      o_instr_pc,
  output logic                 o_instr_valid,
  output imem_pkg::addr_t      o_load_count
);

  import imem_pkg::*;

  // Loader to arbiter
  logic  wr_req;
  addr_t wr_addr;
  word_t wr_data;

  // Fetch unit and arbiter
  logic  rd_req;
  addr_t rd_addr;
  logic  gnt;
  logic  rvalid;

  // Arbiter to RAM
  logic  mem_ena;
  logic  mem_wea;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;   // Straight to the fetch unit

  program_loader u_loader (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_load_start (i_load_start),
    .i_load_valid (i_load_valid),
    .i_load_word  (i_load_word),
    .o_wr_req     (wr_req),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data),
    .o_load_count (o_load_count)
  );

  fetch_unit u_fetch (
    .i_clk           (i_clk),
    .i_rsta          (i_rsta),
    .i_run           (i_run),
    .i_branch        (i_branch),
    .i_branch_target (i_branch_target),
    .i_gnt           (gnt),
    .i_rvalid        (rvalid),
    .i_rdata         (mem_rdata),
    .o_rd_req        (rd_req),
    .o_rd_addr       (rd_addr),
    .o_instr         (o_instr),
    .o_instr_pc      (o_instr_pc),
    .o_instr_valid   (o_instr_valid)
  );

  imem_arbiter u_arb (
    .i_clk       (i_clk),
    .i_rsta      (i_rsta),
    .i_wr_req    (wr_req),
    .i_wr_addr   (wr_addr),
    .i_wr_data   (wr_data),
    .i_rd_req    (rd_req),
    .i_rd_addr   (rd_addr),
    .o_gnt       (gnt),
    .o_rvalid    (rvalid),
    .o_mem_ena   (mem_ena),
    .o_mem_wea   (mem_wea),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata)
  );

  instr_mem u_mem (
    .i_clk  (i_clk),
    .i_ena  (mem_ena),
    .i_wea  (mem_wea),
    .i_addr (mem_addr),
    .i_dina (mem_wdata),
    .o_data (mem_rdata)
  );

endmodule

`default_nettype wire

/* hdl/imem_arbiter.sv */
`default_nettype none

// Fixed-priority owner of the single RAM port
// Loader first, fetch otherwise
module imem_arbiter (
  input  wire                  i_clk,
  input  wire                  i_rsta,
  input  wire                  i_wr_req,      // Loader write level
  input  wire imem_pkg::addr_t i_wr_addr,
  input  wire imem_pkg::word_t i_wr_data,
  input  wire                  i_rd_req,      // Fetch read level
  input  wire imem_pkg::addr_t i_rd_addr,
  output logic                 o_gnt,         // Combinational grant to the fetch unit
  output logic                 o_rvalid,      // Read data belongs to the fetch unit
  output logic                 o_mem_ena,
  output logic                 o_mem_wea,
  output imem_pkg::addr_t      o_mem_addr,
  output imem_pkg::word_t      o_mem_wdata
);

  logic rd_owner;   // Last port cycle was a granted read

  // Write wins, a read is granted only on a free port
  assign o_gnt = i_rd_req && !i_wr_req;

  // Port is idle when nobody asks, so the read register keeps its word
  assign o_mem_ena   = i_wr_req || i_rd_req;
  assign o_mem_wea   = i_wr_req;
  assign o_mem_addr  = i_wr_req ? i_wr_addr : i_rd_addr;
  assign o_mem_wdata = i_wr_data;   // Ignored by the RAM on reads

  // Tag the returning data
  // a write cycle leaves the read register unchanged and gives no strobe
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      rd_owner <= 1'b0;
    end else begin
      rd_owner <= o_gnt;
    end
  end

  assign o_rvalid = rd_owner;

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`default_nettype none

// Sequential instruction fetch with branch redirect
// The RAM word for a granted read is settled before the closing edge of the
// grant cycle, so the instruction is registered on that edge and the PC steps
// at the same time, one instruction per cycle
module fetch_unit (
  input  wire                  i_clk,
  input  wire                  i_rsta,
  input  wire                  i_run,            // Fetch enable level
  input  wire                  i_branch,         // Redirect pulse
  input  wire imem_pkg::addr_t i_branch_target,
  input  wire                  i_gnt,            // Same-cycle grant from the arbiter
  input  wire                  i_rvalid,         // Registered, high after a granted read
  input  wire imem_pkg::word_t i_rdata,          // RAM read register
  output logic                 o_rd_req,
  output imem_pkg::addr_t      o_rd_addr,
  output imem_pkg::word_t      o_instr,
  output imem_pkg::addr_t      o_instr_pc,
  output logic                 o_instr_valid
);

  import imem_pkg::*;

  fetch_state_t state;
  addr_t        pc;            // Address of the next read
  addr_t        inflight_pc;   // Address of the read just granted
  word_t        instr_q;
  logic         rd_fire;       // Read accepted this cycle

  // Request every cycle in RUN, a branch cycle is spent on the redirect
  assign o_rd_req  = (state == FS_RUN) && !i_branch;
  assign o_rd_addr = pc;
  assign rd_fire   = o_rd_req && i_gnt;   // A loader write stalls the fetch

  // State follows the run level
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      state <= FS_IDLE;
    end else begin
      case (state)
        FS_IDLE: if (i_run) state <= FS_RUN;
        FS_RUN:  if (!i_run) state <= FS_IDLE;
        default: state <= FS_IDLE;
      endcase
    end
  end

  // Program counter
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      pc <= '0;
    end else if (i_branch) begin
      pc <= i_branch_target;   // Fetch resumes here next cycle
    end else if (rd_fire) begin
      pc <= pc + 1'b1;         // Wraps 2047 -> 0
    end
  end

  // Word and its address, held until the next granted read
  always_ff @(posedge i_clk) begin
    if (rd_fire) begin
      instr_q     <= i_rdata;  // Captured at the falling edge of this cycle
      inflight_pc <= pc;
    end
  end

  assign o_instr       = instr_q;
  assign o_instr_pc    = inflight_pc;
  assign o_instr_valid = i_rvalid;   // Arbiter marks the cycle after our grant

endmodule

`default_nettype wire

/* hdl/program_loader.sv */
`default_nettype none

// Program loader
// Each strobed word is written at the load pointer, then the pointer steps
module program_loader (
  input  wire                  i_clk,
  input  wire                  i_rsta,
  input  wire                  i_load_start,  // Pulse, restarts loading at address 0
  input  wire                  i_load_valid,  // Strobe, one word per cycle
  input  wire imem_pkg::word_t i_load_word,
  output logic                 o_wr_req,      // Write request level to the arbiter
  output imem_pkg::addr_t      o_wr_addr,
  output imem_pkg::word_t      o_wr_data,
  output imem_pkg::addr_t      o_load_count   // Words written since the last start
);

  import imem_pkg::*;

  addr_t wr_ptr;                 // Next free address

  // Request follows the strobe in the same cycle
  assign o_wr_req  = i_load_valid;
  assign o_wr_data = i_load_word;

  // A start arriving with a word sends that word to address 0
  assign o_wr_addr = i_load_start ? '0 : wr_ptr;

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      wr_ptr <= '0;
    end else if (i_load_start) begin
      wr_ptr <= i_load_valid ? addr_t'(1) : '0;  // Word at 0 already taken
    end else if (i_load_valid) begin
      wr_ptr <= wr_ptr + 1'b1;   // Wraps 2047 -> 0
    end
  end

  // Pointer equals the number of words since start
  assign o_load_count = wr_ptr;

endmodule

`default_nettype wire

/* hdl/instr_mem.sv */
`default_nettype none

// Single-port no-change RAM, one cycle read latency
// Address, data and strobes are captured on the falling edge so the read
// word is settled before the next rising edge
module instr_mem (
  input  wire             i_clk,
  input  wire             i_ena,   // Port enable, idle port keeps its read register
  input  wire             i_wea,   // Write when enabled
  input  wire imem_pkg::addr_t i_addr,
  input  wire imem_pkg::word_t i_dina,
  output imem_pkg::word_t      o_data
);

  import imem_pkg::*;

  word_t mem [IMEM_DEPTH];       // Instruction storage
  word_t ram_data = '0;          // Read register, starts cleared like the array

  // Array comes up all zeros, matching an unprogrammed block RAM
  initial begin
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // No-change behaviour
  // a write leaves the read register alone
  always @(negedge i_clk) begin
    if (i_ena) begin
      if (i_wea) begin
        mem[i_addr] <= i_dina;   // Write only
      end else begin
        ram_data <= mem[i_addr]; // Read only
      end
    end
  end

  assign o_data = ram_data;      // Low latency form, no output register

endmodule

`default_nettype wire

/* hdl/imem_pkg.sv */
`default_nettype none

package imem_pkg;

  // Instruction RAM geometry
  localparam int IMEM_DEPTH = 2048;               // Words in the instruction RAM
  localparam int ADDR_W     = $clog2(IMEM_DEPTH); // 11 bits of word address
  localparam int DATA_W     = 32;                 // One instruction per word

  // Word address, also used for the program counter and the load count
  typedef logic [ADDR_W-1:0] addr_t;

  // One instruction word
  typedef logic [DATA_W-1:0] word_t;

  // Fetch unit states
  // FS_IDLE holds the PC, FS_RUN issues one read per free cycle
  typedef enum logic {
    FS_IDLE = 1'b0,
    FS_RUN  = 1'b1
  } fetch_state_t;

endpackage

`default_nettype wire
